// ==== compile.f ====
source/gl_pkg.sv
source/gl_cmd_fetch.sv
source/gl_decode.sv
source/matrix_stack_ctrl.sv
source/gl_geom_top.sv
bench/gl_geom_props.sv
bench/gl_geom_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= gl_geom_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/gl_geom_tb.sv ====
`timescale 1ns/1ps

module gl_geom_tb;

    localparam int NUM_TESTS   = 8;
    localparam int MAX_CMDS    = 16;
    localparam int RUN_TIMEOUT = 400;

    logic                            clk;
    logic                            rst;
    logic                            cmd_wr_en;
    logic [gl_pkg::CMD_ADDR_W-1:0]   cmd_wr_addr;
    logic [gl_pkg::CMD_W-1:0]        cmd_wr_data;
    logic [gl_pkg::CMD_ADDR_W:0]     cmd_count;
    logic                            start;
    logic                            busy;
    logic                            done;
    logic [gl_pkg::DATA_W-1:0]       bram_addr_in;
    logic [gl_pkg::DATA_W-1:0]       bram_read_0;
    logic [gl_pkg::DATA_W-1:0]       bram_read_1;
    logic [gl_pkg::DATA_W-1:0]       bram_read_2;
    logic [gl_pkg::DATA_W-1:0]       bram_read_3;
    logic [gl_pkg::DATA_W-1:0]       bram_addr;
    logic [gl_pkg::DATA_W-1:0]       viewport_x;
    logic [gl_pkg::DATA_W-1:0]       viewport_y;
    logic [gl_pkg::DATA_W-1:0]       viewport_width;
    logic [gl_pkg::DATA_W-1:0]       viewport_height;
    logic [gl_pkg::DATA_W-1:0]       color;
    logic                            push_en;
    logic                            pop_en;
    logic                            matrix_load_en;
    logic                            matrix_load_id_en;
    logic                            matrix_mul_en;
    logic                            matrix_mul_type;
    logic                            matrix_mode;
    logic                            perspective_div_en;
    logic                            stall;
    logic [gl_pkg::DEPTH_W-1:0]      depth_proj;
    logic [gl_pkg::DEPTH_W-1:0]      depth_mv;
    logic                            overflow;
    logic                            underflow;

    //////////////////////////////////////////////////
    // Test table
    //////////////////////////////////////////////////

    string       t_name      [NUM_TESTS];
    logic [31:0] t_cmd       [NUM_TESTS][MAX_CMDS];
    int          t_count     [NUM_TESTS];
    int          t_exp_int   [NUM_TESTS][14];
    bit          t_lat_color [NUM_TESTS];
    bit          t_lat_vp    [NUM_TESTS];
    bit          t_lat_addr  [NUM_TESTS];
    int          cur;

    // Observed counts in the order of the expected columns
    int          n_obs [10];
    logic [31:0] lfsr_state;
    int          test_errors;
    int          pass_tests;
    int          fail_tests;
    int          mismatches;
    bit          timed_out;

    gl_geom_top gl_geom_top_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic draw_word(output logic [31:0] w);
        int k;
        w = '0;
        for (k = 0; k < 32; k++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    // Expected columns in order are busy cycles, done, mul, mul type 1, div, load,
    // load id, push, pop, modelview mul, depth_proj, depth_mv, overflow, underflow
    task automatic set_expect(input int idx, input string name, input int e [14],
                              input bit lc, input bit lv, input bit la);
        cur              = idx;
        t_name[idx]      = name;
        t_exp_int[idx]   = e;
        t_lat_color[idx] = lc;
        t_lat_vp[idx]    = lv;
        t_lat_addr[idx]  = la;
    endtask

    task automatic add_cmd(input logic [7:0] op, input logic ty, input logic [22:0] iv);
        t_cmd[cur][t_count[cur]] = {op, ty, iv};
        t_count[cur]++;
    endtask

    task automatic build_table();
        set_expect(0, "empty_program", '{1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}, 0, 0, 0);

        set_expect(1, "color_viewport", '{5, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}, 1, 1, 0);
        add_cmd(gl_pkg::OP_COLOR, 1'b0, '0);
        add_cmd(gl_pkg::OP_VIEWPORT, 1'b0, '0);

        set_expect(2, "stack_modes", '{17, 1, 0, 0, 0, 0, 0, 5, 1, 0, 2, 2, 0, 0}, 0, 0, 0);
        add_cmd(gl_pkg::OP_MATRIXMODE, 1'b0, 23'd1);
        repeat (3) add_cmd(gl_pkg::OP_PUSHMATRIX, 1'b0, '0);
        add_cmd(gl_pkg::OP_POPMATRIX, 1'b0, '0);
        add_cmd(gl_pkg::OP_MATRIXMODE, 1'b0, 23'd0);
        repeat (2) add_cmd(gl_pkg::OP_PUSHMATRIX, 1'b0, '0);

        set_expect(3, "stack_errors", '{25, 1, 0, 0, 0, 0, 0, 9, 1, 0, 0, 8, 1, 1}, 0, 0, 0);
        add_cmd(gl_pkg::OP_MATRIXMODE, 1'b0, 23'd1);
        repeat (9) add_cmd(gl_pkg::OP_PUSHMATRIX, 1'b0, '0);
        add_cmd(gl_pkg::OP_MATRIXMODE, 1'b0, 23'd0);
        add_cmd(gl_pkg::OP_POPMATRIX, 1'b0, '0);

        // Each multiply takes 13 stall cycles, a retire cycle and a gap cycle
        set_expect(4, "multiply", '{61, 1, 4, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0}, 0, 0, 0);
        add_cmd(gl_pkg::OP_MULTMATRIX, 1'b0, '0);
        add_cmd(gl_pkg::OP_ROTATE, 1'b0, '0);
        add_cmd(gl_pkg::OP_SCALE, 1'b0, '0);
        add_cmd(gl_pkg::OP_TRANSLATE, 1'b0, '0);

        set_expect(5, "vertex", '{12, 1, 2, 0, 1, 0, 0, 0, 0, 1, 0, 0, 0, 0}, 0, 0, 0);
        add_cmd(gl_pkg::OP_VERTEX, 1'b0, '0);

        set_expect(6, "load_matrix", '{8, 1, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0, 0}, 0, 0, 1);
        add_cmd(gl_pkg::OP_LOADMATRIX, 1'b0, '0);
        add_cmd(gl_pkg::OP_LOADID, 1'b0, '0);

        set_expect(7, "mixed_program", '{50, 1, 3, 3, 1, 1, 1, 2, 0, 2, 1, 1, 0, 0}, 1, 1, 1);
        add_cmd(gl_pkg::OP_MATRIXMODE, 1'b0, 23'd1);
        add_cmd(gl_pkg::OP_LOADID, 1'b0, '0);
        add_cmd(gl_pkg::OP_PUSHMATRIX, 1'b0, '0);
        add_cmd(gl_pkg::OP_COLOR, 1'b0, '0);
        add_cmd(gl_pkg::OP_VIEWPORT, 1'b0, '0);
        add_cmd(gl_pkg::OP_MULTMATRIX, 1'b1, '0);
        add_cmd(gl_pkg::OP_VERTEX, 1'b1, '0);
        add_cmd(gl_pkg::OP_MATRIXMODE, 1'b0, 23'd0);
        add_cmd(gl_pkg::OP_LOADMATRIX, 1'b0, '0);
        add_cmd(gl_pkg::OP_PUSHMATRIX, 1'b0, '0);
        add_cmd(gl_pkg::OP_FRUSTUM, 1'b0, '0);
        add_cmd(gl_pkg::OP_END, 1'b0, '0);
    endtask

    //////////////////////////////////////////////////
    // Driving and observing
    //////////////////////////////////////////////////

    task automatic apply_reset();
        @(posedge clk);
        #1 rst = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
    endtask

    task automatic load_program(input int t);
        int i;
        for (i = 0; i < t_count[t]; i++)
        begin
            cmd_wr_en   = 1'b1;
            cmd_wr_addr = 4'(i);
            cmd_wr_data = t_cmd[t][i];
            @(posedge clk);
            #1;
        end
        cmd_wr_en = 1'b0;
        cmd_count = 5'(t_count[t]);
    endtask

    task automatic sample_outputs();
        if (busy)
            n_obs[0]++;
        if (done)
            n_obs[1]++;
        if (matrix_mul_en)
            n_obs[2]++;
        if (matrix_mul_en && matrix_mul_type)
            n_obs[3]++;
        if (perspective_div_en)
            n_obs[4]++;
        if (matrix_load_en)
            n_obs[5]++;
        if (matrix_load_id_en)
            n_obs[6]++;
        if (push_en)
            n_obs[7]++;
        if (pop_en)
            n_obs[8]++;
        // Multiply pulses aimed at the modelview stack
        if (matrix_mul_en && matrix_mode)
            n_obs[9]++;
    endtask

    task automatic check_value(input string tname, input string what,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
        assert (act_v === exp_v)
        else
        begin
            $display("FAIL %s %s: expected %0h, actual %0h", tname, what, exp_v, act_v);
            test_errors++;
        end
    endtask

    task automatic run_test(input int t);
        logic [31:0] rd [4];
        logic [31:0] addr_v;
        int          i;
        int          cycles;
        bit          finished;
        string       col_names [10];
        col_names   = '{"busy cycles", "done pulses", "mul pulses", "mul type 1 pulses",
                        "div pulses", "load pulses", "load id pulses", "push pulses",
                        "pop pulses", "modelview mul pulses"};
        test_errors = 0;
        for (i = 0; i < 4; i++)
            draw_word(rd[i]);
        draw_word(addr_v);
        apply_reset();
        bram_read_0  = rd[0];
        bram_read_1  = rd[1];
        bram_read_2  = rd[2];
        bram_read_3  = rd[3];
        bram_addr_in = addr_v;
        load_program(t);
        n_obs = '{default: 0};

        start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;

        cycles   = 0;
        finished = 1'b0;
        while (!finished && cycles < RUN_TIMEOUT)
        begin
            @(negedge clk);
            sample_outputs();
            cycles++;
            if (done)
                finished = 1'b1;
        end
        // A few more cycles to catch stray strobes or a second done
        repeat (3)
        begin
            @(negedge clk);
            sample_outputs();
        end

        if (!finished)
        begin
            $display("Test %s timed out waiting for done", t_name[t]);
            timed_out = 1'b1;
            test_errors++;
        end
        else
        begin
            for (i = 0; i < 10; i++)
                check_value(t_name[t], col_names[i], 32'(t_exp_int[t][i]), 32'(n_obs[i]));
            check_value(t_name[t], "depth_proj", 32'(t_exp_int[t][10]), 32'(depth_proj));
            check_value(t_name[t], "depth_mv", 32'(t_exp_int[t][11]), 32'(depth_mv));
            check_value(t_name[t], "overflow", 32'(t_exp_int[t][12]), 32'(overflow));
            check_value(t_name[t], "underflow", 32'(t_exp_int[t][13]), 32'(underflow));
            check_value(t_name[t], "color", t_lat_color[t] ? rd[0] : 32'h0, color);
            check_value(t_name[t], "viewport_x", t_lat_vp[t] ? rd[0] : 32'h0, viewport_x);
            check_value(t_name[t], "viewport_y", t_lat_vp[t] ? rd[1] : 32'h0, viewport_y);
            // 640.0 and 480.0 after reset
            check_value(t_name[t], "viewport_width",
                        t_lat_vp[t] ? rd[2] : 32'h4420_0000, viewport_width);
            check_value(t_name[t], "viewport_height",
                        t_lat_vp[t] ? rd[3] : 32'h43F0_0000, viewport_height);
            // Base plus three row steps of 16 bytes
            check_value(t_name[t], "bram_addr",
                        t_lat_addr[t] ? addr_v + 32'd48 : 32'h0, bram_addr);
            check_value(t_name[t], "busy after done", 32'h0, 32'(busy));
            check_value(t_name[t], "stall after done", 32'h0, 32'(stall));
        end

        mismatches += test_errors;
        if (test_errors == 0)
        begin
            pass_tests++;
            $display("test %s ok, %0d busy cycles", t_name[t], n_obs[0]);
        end
        else
        begin
            fail_tests++;
            $display("test %s had %0d errors", t_name[t], test_errors);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial
    begin
        int t;
        rst          = 1'b1;
        cmd_wr_en    = 1'b0;
        cmd_wr_addr  = '0;
        cmd_wr_data  = '0;
        cmd_count    = '0;
        start        = 1'b0;
        bram_addr_in = '0;
        bram_read_0  = '0;
        bram_read_1  = '0;
        bram_read_2  = '0;
        bram_read_3  = '0;
        lfsr_state   = 32'd31;
        pass_tests   = 0;
        fail_tests   = 0;
        mismatches   = 0;
        timed_out    = 1'b0;
        build_table();

        for (t = 0; t < NUM_TESTS && !timed_out; t++)
            run_test(t);

        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 pass_tests + fail_tests, pass_tests, fail_tests, mismatches);
        if (fail_tests == 0 && !timed_out)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== bench/gl_geom_props.sv ====
`timescale 1ns/1ps

module gl_geom_props
(
    input logic               clk,
    input logic               rst,
    input logic               push_en,
    input logic               pop_en,
    input logic               matrix_mul_en,
    input logic               cmd_valid,
    input logic               stall,
    input gl_pkg::dec_state_e state
);

    // Stack controller takes one operation per cycle
    push_pop_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(push_en && pop_en))
        else $error("push_en and pop_en high in the same cycle");

    // Every multiply request is a single-cycle strobe
    mul_single_pulse: assert property (@(posedge clk) disable iff (rst)
        matrix_mul_en |=> !matrix_mul_en)
        else $error("matrix_mul_en held high for two cycles");

    // Sequences and stalls only while fetch presents a command
    no_stall_without_cmd: assert property (@(posedge clk) disable iff (rst)
        !cmd_valid |-> (!stall && state != gl_pkg::DEC_SEQ))
        else $error("stall or command sequence while cmd_valid is low");

endmodule

bind gl_decode gl_geom_props gl_geom_props_i
(
    .clk           (clk),
    .rst           (rst),
    .push_en       (push_en),
    .pop_en        (pop_en),
    .matrix_mul_en (matrix_mul_en),
    .cmd_valid     (cmd_valid),
    .stall         (stall),
    .state         (state)
);

// ==== source/gl_geom_top.sv ====
`timescale 1ns/1ps

module gl_geom_top
(
    input  logic                            clk,
    input  logic                            rst,
    // Host side
    input  logic                            cmd_wr_en,
    input  logic [gl_pkg::CMD_ADDR_W-1:0]   cmd_wr_addr,
    input  logic [gl_pkg::CMD_W-1:0]        cmd_wr_data,
    input  logic [gl_pkg::CMD_ADDR_W:0]     cmd_count,
    input  logic                            start,
    output logic                            busy,
    output logic                            done,
    // Data side
    input  logic [gl_pkg::DATA_W-1:0]       bram_addr_in,
    input  logic [gl_pkg::DATA_W-1:0]       bram_read_0,
    input  logic [gl_pkg::DATA_W-1:0]       bram_read_1,
    input  logic [gl_pkg::DATA_W-1:0]       bram_read_2,
    input  logic [gl_pkg::DATA_W-1:0]       bram_read_3,
    output logic [gl_pkg::DATA_W-1:0]       bram_addr,
    output logic [gl_pkg::DATA_W-1:0]       viewport_x,
    output logic [gl_pkg::DATA_W-1:0]       viewport_y,
    output logic [gl_pkg::DATA_W-1:0]       viewport_width,
    output logic [gl_pkg::DATA_W-1:0]       viewport_height,
    output logic [gl_pkg::DATA_W-1:0]       color,
    // Transform strobes
    output logic                            push_en,
    output logic                            pop_en,
    output logic                            matrix_load_en,
    output logic                            matrix_load_id_en,
    output logic                            matrix_mul_en,
    output logic                            matrix_mul_type,
    output logic                            matrix_mode,
    output logic                            perspective_div_en,
    output logic                            stall,
    // Stack status
    output logic [gl_pkg::DEPTH_W-1:0]      depth_proj,
    output logic [gl_pkg::DEPTH_W-1:0]      depth_mv,
    output logic                            overflow,
    output logic                            underflow
);

    gl_pkg::gl_op_e               opcode;
    logic [gl_pkg::IMM_W-1:0]     imm;
    logic                         cmd_type;
    logic                         cmd_valid;

    gl_cmd_fetch gl_cmd_fetch_i
    (
        .clk         (clk),
        .rst         (rst),
        .cmd_wr_en   (cmd_wr_en),
        .cmd_wr_addr (cmd_wr_addr),
        .cmd_wr_data (cmd_wr_data),
        .cmd_count   (cmd_count),
        .start       (start),
        .stall       (stall),
        .opcode      (opcode),
        .imm         (imm),
        .cmd_type    (cmd_type),
        .cmd_valid   (cmd_valid),
        .busy        (busy),
        .done        (done)
    );

    gl_decode gl_decode_i
    (
        .clk                (clk),
        .rst                (rst),
        .opcode             (opcode),
        .imm                (imm),
        .cmd_type           (cmd_type),
        .cmd_valid          (cmd_valid),
        .bram_addr_in       (bram_addr_in),
        .bram_read_0        (bram_read_0),
        .bram_read_1        (bram_read_1),
        .bram_read_2        (bram_read_2),
        .bram_read_3        (bram_read_3),
        .bram_addr          (bram_addr),
        .viewport_x         (viewport_x),
        .viewport_y         (viewport_y),
        .viewport_width     (viewport_width),
        .viewport_height    (viewport_height),
        .color              (color),
        .push_en            (push_en),
        .pop_en             (pop_en),
        .matrix_load_en     (matrix_load_en),
        .matrix_load_id_en  (matrix_load_id_en),
        .matrix_mul_en      (matrix_mul_en),
        .matrix_mul_type    (matrix_mul_type),
        .matrix_mode        (matrix_mode),
        .perspective_div_en (perspective_div_en),
        .stall              (stall)
    );

    matrix_stack_ctrl matrix_stack_ctrl_i
    (
        .clk         (clk),
        .rst         (rst),
        .push_en     (push_en),
        .pop_en      (pop_en),
        .matrix_mode (matrix_mode),
        .depth_proj  (depth_proj),
        .depth_mv    (depth_mv),
        .overflow    (overflow),
        .underflow   (underflow)
    );

endmodule

// ==== source/matrix_stack_ctrl.sv ====
`timescale 1ns/1ps

module matrix_stack_ctrl
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           push_en,
    input  logic                           pop_en,
    input  logic                           matrix_mode,
    output logic [gl_pkg::DEPTH_W-1:0]     depth_proj,
    output logic [gl_pkg::DEPTH_W-1:0]     depth_mv,
    output logic                           overflow,
    output logic                           underflow
);

    // Index 0 is projection, index 1 is modelview
    logic [gl_pkg::DEPTH_W-1:0] depth [2];
    logic [gl_pkg::DEPTH_W-1:0] sel_depth;

    assign sel_depth = depth[matrix_mode];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            depth[0]  <= '0;
            depth[1]  <= '0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end
        else
        begin
            if (push_en)
            begin
                // Full stack keeps its depth
                if (sel_depth == gl_pkg::DEPTH_W'(gl_pkg::STACK_DEPTH))
                    overflow <= 1'b1;
                else
                    depth[matrix_mode] <= sel_depth + 1'b1;
            end
            else if (pop_en)
            begin
                if (sel_depth == '0)
                    underflow <= 1'b1;
                else
                    depth[matrix_mode] <= sel_depth - 1'b1;
            end
        end
    end

    assign depth_proj = depth[0];
    assign depth_mv   = depth[1];

endmodule

// ==== source/gl_decode.sv ====
`timescale 1ns/1ps

module gl_decode
(
    input  logic                         clk,
    input  logic                         rst,
    input  gl_pkg::gl_op_e               opcode,
    input  logic [gl_pkg::IMM_W-1:0]     imm,
    input  logic                         cmd_type,
    input  logic                         cmd_valid,
    input  logic [gl_pkg::DATA_W-1:0]    bram_addr_in,
    input  logic [gl_pkg::DATA_W-1:0]    bram_read_0,
    input  logic [gl_pkg::DATA_W-1:0]    bram_read_1,
    input  logic [gl_pkg::DATA_W-1:0]    bram_read_2,
    input  logic [gl_pkg::DATA_W-1:0]    bram_read_3,
    output logic [gl_pkg::DATA_W-1:0]    bram_addr,
    output logic [gl_pkg::DATA_W-1:0]    viewport_x,
    output logic [gl_pkg::DATA_W-1:0]    viewport_y,
    output logic [gl_pkg::DATA_W-1:0]    viewport_width,
    output logic [gl_pkg::DATA_W-1:0]    viewport_height,
    output logic [gl_pkg::DATA_W-1:0]    color,
    output logic                         push_en,
    output logic                         pop_en,
    output logic                         matrix_load_en,
    output logic                         matrix_load_id_en,
    output logic                         matrix_mul_en,
    output logic                         matrix_mul_type,
    output logic                         matrix_mode,
    output logic                         perspective_div_en,
    output logic                         stall
);

    gl_pkg::dec_state_e           state;
    logic [gl_pkg::CNT_W-1:0]     cnt;
    logic                         curr_mode;
    logic                         is_multi;

    always_comb
    begin
        case (opcode)
            gl_pkg::OP_MULTMATRIX, gl_pkg::OP_ROTATE, gl_pkg::OP_SCALE,
            gl_pkg::OP_TRANSLATE, gl_pkg::OP_VERTEX, gl_pkg::OP_LOADMATRIX:
                is_multi = 1'b1;
            default:
                is_multi = 1'b0;
        endcase
    end

    // High from the first cycle of a long command until its count runs out
    assign stall = (state == gl_pkg::DEC_IDLE && cmd_valid && is_multi) ||
                   (state == gl_pkg::DEC_SEQ && cnt != '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state              <= gl_pkg::DEC_IDLE;
            cnt                <= '0;
            curr_mode          <= 1'b0;
            matrix_mode        <= 1'b0;
            matrix_mul_type    <= 1'b0;
            push_en            <= 1'b0;
            pop_en             <= 1'b0;
            matrix_load_en     <= 1'b0;
            matrix_load_id_en  <= 1'b0;
            matrix_mul_en      <= 1'b0;
            perspective_div_en <= 1'b0;
            bram_addr          <= '0;
            color              <= '0;
            viewport_x         <= '0;
            viewport_y         <= '0;
            viewport_width     <= gl_pkg::VIEWPORT_W_RESET;
            viewport_height    <= gl_pkg::VIEWPORT_H_RESET;
        end
        else
        begin
            push_en            <= 1'b0;
            pop_en             <= 1'b0;
            matrix_load_en     <= 1'b0;
            matrix_load_id_en  <= 1'b0;
            matrix_mul_en      <= 1'b0;
            perspective_div_en <= 1'b0;

            case (state)
                //////////////////////////////////////////////////
                // First cycle of each command
                //////////////////////////////////////////////////
                gl_pkg::DEC_IDLE:
                begin
                    if (cmd_valid)
                    begin
                        if (is_multi)
                            state <= gl_pkg::DEC_SEQ;
                        case (opcode)
                            gl_pkg::OP_VERTEX:
                            begin
                                // Modelview pass first, type bit picks the form
                                matrix_mul_en   <= 1'b1;
                                matrix_mul_type <= cmd_type;
                                matrix_mode     <= 1'b1;
                                cnt <= gl_pkg::CNT_W'(gl_pkg::VERTEX_CYCLES - 1);
                            end
                            gl_pkg::OP_MULTMATRIX, gl_pkg::OP_ROTATE,
                            gl_pkg::OP_SCALE, gl_pkg::OP_TRANSLATE:
                            begin
                                matrix_mul_en   <= 1'b1;
                                matrix_mul_type <= 1'b1;
                                matrix_mode     <= curr_mode;
                                cnt <= gl_pkg::CNT_W'(gl_pkg::MUL_CYCLES - 3);
                            end
                            gl_pkg::OP_LOADMATRIX:
                            begin
                                matrix_load_en <= 1'b1;
                                matrix_mode    <= curr_mode;
                                bram_addr      <= bram_addr_in;
                                cnt <= gl_pkg::CNT_W'(gl_pkg::LOAD_CYCLES - 1);
                            end
                            gl_pkg::OP_COLOR:
                                color <= bram_read_0;
                            gl_pkg::OP_MATRIXMODE:
                                curr_mode <= imm[0];
                            gl_pkg::OP_LOADID:
                            begin
                                matrix_load_id_en <= 1'b1;
                                matrix_mode       <= curr_mode;
                            end
                            gl_pkg::OP_PUSHMATRIX:
                            begin
                                push_en     <= 1'b1;
                                matrix_mode <= curr_mode;
                            end
                            gl_pkg::OP_POPMATRIX:
                            begin
                                pop_en      <= 1'b1;
                                matrix_mode <= curr_mode;
                            end
                            gl_pkg::OP_VIEWPORT:
                            begin
                                viewport_x      <= bram_read_0;
                                viewport_y      <= bram_read_1;
                                viewport_width  <= bram_read_2;
                                viewport_height <= bram_read_3;
                            end
                            // BEGIN, END and FRUSTUM have no effect
                            default:
                            begin
                            end
                        endcase
                    end
                end

                gl_pkg::DEC_SEQ:
                begin
                    if (opcode == gl_pkg::OP_VERTEX && cnt == gl_pkg::VTX_PROJ_CNT)
                    begin
                        // Projection pass
                        matrix_mul_en <= 1'b1;
                        matrix_mode   <= 1'b0;
                    end
                    if (opcode == gl_pkg::OP_VERTEX && cnt == gl_pkg::VTX_DIV_CNT)
                        perspective_div_en <= 1'b1;
                    if (opcode == gl_pkg::OP_LOADMATRIX)
                        bram_addr <= bram_addr + gl_pkg::ROW_STRIDE;

                    if (cnt == '0)
                        state <= gl_pkg::DEC_WAIT;
                    else
                        cnt <= cnt - 1'b1;
                end

                // Fetch drops cmd_valid here
                default:
                    state <= gl_pkg::DEC_IDLE;
            endcase
        end
    end

endmodule

// ==== source/gl_cmd_fetch.sv ====
`timescale 1ns/1ps

module gl_cmd_fetch
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cmd_wr_en,
    input  logic [gl_pkg::CMD_ADDR_W-1:0]   cmd_wr_addr,
    input  logic [gl_pkg::CMD_W-1:0]        cmd_wr_data,
    input  logic [gl_pkg::CMD_ADDR_W:0]     cmd_count,
    input  logic                            start,
    input  logic                            stall,
    output gl_pkg::gl_op_e                  opcode,
    output logic [gl_pkg::IMM_W-1:0]        imm,
    output logic                            cmd_type,
    output logic                            cmd_valid,
    output logic                            busy,
    output logic                            done
);

    logic [gl_pkg::CMD_W-1:0]      cmd_mem [2**gl_pkg::CMD_ADDR_W];
    logic [gl_pkg::CMD_W-1:0]      cmd_word;
    logic [gl_pkg::CMD_ADDR_W-1:0] pc;
    logic [gl_pkg::CMD_ADDR_W:0]   retired;

    // Host write port
    always_ff @(posedge clk)
    begin
        if (cmd_wr_en)
            cmd_mem[cmd_wr_addr] <= cmd_wr_data;
    end

    // Present, hold while stalled, retire, then one idle cycle
    always_ff @(posedge clk)
    begin
        cmd_word <= cmd_mem[pc];
        if (rst)
        begin
            pc        <= '0;
            retired   <= '0;
            cmd_valid <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (!busy)
            begin
                if (start)
                begin
                    busy    <= 1'b1;
                    pc      <= '0;
                    retired <= '0;
                end
            end
            else if (!cmd_valid)
            begin
                if (retired == cmd_count)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
                else
                    cmd_valid <= 1'b1;
            end
            else if (!stall)
            begin
                cmd_valid <= 1'b0;
                pc        <= pc + 1'b1;
                retired   <= retired + 1'b1;
            end
        end
    end

    assign opcode   = gl_pkg::gl_op_e'(cmd_word[gl_pkg::CMD_W-1 -: gl_pkg::OP_W]);
    assign cmd_type = cmd_word[gl_pkg::IMM_W];
    assign imm      = cmd_word[gl_pkg::IMM_W-1:0];

endmodule

// ==== source/gl_pkg.sv ====
package gl_pkg;

    //////////////////////////////////////////////////
    // Command word format
    //////////////////////////////////////////////////

    // Opcode in 31..24, type bit in 23, immediate in 22..0
    localparam int CMD_W      = 32;
    localparam int OP_W       = 8;
    localparam int IMM_W      = 23;
    localparam int CMD_ADDR_W = 4;
    localparam int DATA_W     = 32;

    typedef enum logic [OP_W-1:0] {
        OP_BEGIN      = 8'd0,
        OP_END        = 8'd1,
        OP_VERTEX     = 8'd3,
        OP_COLOR      = 8'd4,
        OP_MATRIXMODE = 8'd16,
        OP_MULTMATRIX = 8'd17,
        OP_LOADID     = 8'd18,
        OP_LOADMATRIX = 8'd19,
        OP_PUSHMATRIX = 8'd20,
        OP_POPMATRIX  = 8'd21,
        OP_ROTATE     = 8'd22,
        OP_SCALE      = 8'd23,
        OP_TRANSLATE  = 8'd24,
        OP_VIEWPORT   = 8'd25,
        OP_FRUSTUM    = 8'd26
    } gl_op_e;

    //////////////////////////////////////////////////
    // Decoder sequencing
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_SEQ,
        DEC_WAIT
    } dec_state_e;

    localparam int CNT_W         = 4;
    localparam int MUL_CYCLES    = 15;
    localparam int VERTEX_CYCLES = 9;
    localparam int LOAD_CYCLES   = 3;

    // Counter taps inside a vertex transform
    localparam int VTX_PROJ_CNT = VERTEX_CYCLES - 3;
    localparam int VTX_DIV_CNT  = 3;

    localparam int ROW_STRIDE  = 16;
    localparam int STACK_DEPTH = 8;
    localparam int DEPTH_W     = 4;

    // 640.0 and 480.0 in single precision
    localparam logic [DATA_W-1:0] VIEWPORT_W_RESET = 32'h4420_0000;
    localparam logic [DATA_W-1:0] VIEWPORT_H_RESET = 32'h43F0_0000;

endpackage
